// ==== logic/cdc_macros.svh ====
// Sizing constants for the command crossing, include this before cdc_pkg or any module using them
`ifndef CDC_MACROS_SVH
`define CDC_MACROS_SVH

// FIFO depth as a power of two, 2**3 gives eight entries
`define CDC_LOG_DEPTH 3

// Width of the command operand and of the destination accumulator
`define CMD_OPERAND_W 16

// Width of the running sequence number stamped on each command
// The counter wraps, so 4 bits repeat every 16 commands
`define CMD_SEQ_W 4

`endif

// ==== logic/cdc_pkg.sv ====
// Shared types for the command crossing, imported by the issuer, accumulator and top level
`default_nettype none

`include "cdc_macros.svh"

package cdc_pkg;

  // Arithmetic operations carried by a command
  typedef enum logic [1:0] {
    OP_LOAD = 2'd0,
    OP_ADD  = 2'd1,
    OP_SUB  = 2'd2,
    OP_XOR  = 2'd3
  } opcode_e;

  // Control state of the destination accumulator
  // HOLD keeps the result on the port until it is taken
  typedef enum logic {
    ACC_IDLE = 1'b0,
    ACC_HOLD = 1'b1
  } acc_state_e;

  // Word pushed through the FIFO, 2 + 4 + 16 = 22 bits
  typedef struct packed {
    opcode_e                   op;
    logic [`CMD_SEQ_W-1:0]     seq;
    logic [`CMD_OPERAND_W-1:0] operand;
  } cmd_word_t;

endpackage

`default_nettype wire

// ==== logic/cdc_2phase.sv ====
// Two-phase toggle synchronizer that keeps copying a multi-bit value into another clock domain
`default_nettype none

module cdc_2phase #(
  parameter int WIDTH = 4
) (
  input  wire logic             src_rst_ni,
  input  wire logic             src_clk_i,
  input  wire logic [WIDTH-1:0] src_data_i,
  input  wire logic             dst_rst_ni,
  input  wire logic             dst_clk_i,
  output logic      [WIDTH-1:0] dst_data_o
);

  // Holding register, request toggle and synchronized acknowledge on the source side
  logic [WIDTH-1:0] data_src_q;
  logic             req_src_q;
  logic [1:0]       ack_src_q;
  logic             req_pending;

  // Synchronized request, acknowledge toggle and captured copy on the destination side
  logic [1:0]       req_dst_q;
  logic             ack_dst_q;
  logic [WIDTH-1:0] data_dst_q;

  // A transfer is outstanding until the acknowledge comes back with the request's phase
  assign req_pending = (req_src_q != ack_src_q[1]);

  // Sample a fresh value and flip the request whenever the previous one has landed
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      data_src_q <= '0;
      req_src_q  <= 1'b0;
    end else if (!req_pending) begin
      data_src_q <= src_data_i;
      req_src_q  <= ~req_src_q;
    end
  end

  // Bring the acknowledge back into the source domain through two flops
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      ack_src_q <= 2'b00;
    end else begin
      ack_src_q <= {ack_src_q[0], ack_dst_q};
    end
  end

  // Two flops on the request before anything in this domain looks at it
  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      req_dst_q <= 2'b00;
    end else begin
      req_dst_q <= {req_dst_q[0], req_src_q};
    end
  end

  // On a phase change the held value has been stable for two cycles, so capture it
  // The acknowledge simply follows the request phase that was seen last
  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      ack_dst_q  <= 1'b0;
      data_dst_q <= '0;
    end else if (req_dst_q[1] != ack_dst_q) begin
      ack_dst_q  <= req_dst_q[1];
      data_dst_q <= data_src_q;
    end
  end

  assign dst_data_o = data_dst_q;

  // The held value must sit still across the last destination cycle before it is captured
  // This only holds if the acknowledge path keeps the source from resampling too early
  hold_stable_a : assert property (
    @(posedge dst_clk_i) disable iff (!dst_rst_ni)
    (req_dst_q[1] != ack_dst_q) |-> $stable(data_src_q)
  ) else $error("cdc_2phase: held data changed while a request was outstanding");

endmodule

`default_nettype wire

// ==== logic/cdc_fifo.sv ====
// Dual-clock FIFO with a register memory, used to hand payloads from a source to a destination domain
`default_nettype none

module cdc_fifo #(
  parameter type T         = logic,
  parameter int  LOG_DEPTH = 3
) (
  input  wire logic src_rst_ni,
  input  wire logic src_clk_i,
  input  wire T     src_data_i,
  input  wire logic src_valid_i,
  output logic      src_ready_o,

  input  wire logic dst_rst_ni,
  input  wire logic dst_clk_i,
  output T          dst_data_o,
  output logic      dst_valid_o,
  input  wire logic dst_ready_i
);

  localparam int DEPTH     = 2 ** LOG_DEPTH;
  localparam int PTR_WIDTH = LOG_DEPTH + 1;

  typedef logic [PTR_WIDTH-1:0] pointer_t;
  typedef logic [LOG_DEPTH-1:0] index_t;

  // Pointer difference patterns for a full and an empty buffer
  localparam pointer_t PTR_FULL  = pointer_t'(DEPTH);
  localparam pointer_t PTR_EMPTY = '0;

  // Storage, written from the source clock and read without a clock
  T mem_q [DEPTH];

  // Local pointers and the copies that crossed over from the other side
  pointer_t src_wptr_q;
  pointer_t src_rptr;
  pointer_t dst_rptr_q;
  pointer_t dst_wptr;

  index_t   wr_idx;
  index_t   rd_idx;
  logic     push;
  logic     pop;

  // Zero-depth buffers make no sense with this pointer scheme
  initial begin
    assert (LOG_DEPTH >= 1)
      else $fatal(1, "cdc_fifo: LOG_DEPTH must be at least 1");
  end

  assign push   = src_valid_i && src_ready_o;
  assign pop    = dst_valid_o && dst_ready_i;
  assign wr_idx = src_wptr_q[LOG_DEPTH-1:0];
  assign rd_idx = dst_rptr_q[LOG_DEPTH-1:0];

  // The write pointer only moves after the entry has been stored
  always_ff @(posedge src_clk_i) begin
    if (push) begin
      mem_q[wr_idx] <= src_data_i;
    end
  end

  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      src_wptr_q <= '0;
    end else if (push) begin
      src_wptr_q <= src_wptr_q + 1'b1;
    end
  end

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      dst_rptr_q <= '0;
    end else if (pop) begin
      dst_rptr_q <= dst_rptr_q + 1'b1;
    end
  end

  // Same index with different wrap bits means full, equal pointers mean empty
  // Both views are pessimistic because the crossed copy lags behind
  assign src_ready_o = ((src_wptr_q ^ src_rptr) != PTR_FULL);
  assign dst_valid_o = ((dst_rptr_q ^ dst_wptr) != PTR_EMPTY);
  assign dst_data_o  = mem_q[rd_idx];

  // Write pointer into the destination domain
  cdc_2phase #(
    .WIDTH (PTR_WIDTH)
  ) i_cdc_wptr (
    .src_rst_ni (src_rst_ni),
    .src_clk_i  (src_clk_i),
    .src_data_i (src_wptr_q),
    .dst_rst_ni (dst_rst_ni),
    .dst_clk_i  (dst_clk_i),
    .dst_data_o (dst_wptr)
  );

  // Read pointer back into the source domain
  cdc_2phase #(
    .WIDTH (PTR_WIDTH)
  ) i_cdc_rptr (
    .src_rst_ni (dst_rst_ni),
    .src_clk_i  (dst_clk_i),
    .src_data_i (dst_rptr_q),
    .dst_rst_ni (src_rst_ni),
    .dst_clk_i  (src_clk_i),
    .dst_data_o (src_rptr)
  );

  // The writer never runs more than a full buffer ahead of the reader it has seen
  no_overflow_a : assert property (
    @(posedge src_clk_i) disable iff (!src_rst_ni)
    pointer_t'(src_wptr_q - src_rptr) <= PTR_FULL
  ) else $error("cdc_fifo: push while full");

  // The reader never passes the write pointer it has seen
  no_underflow_a : assert property (
    @(posedge dst_clk_i) disable iff (!dst_rst_ni)
    pointer_t'(dst_wptr - dst_rptr_q) <= PTR_FULL
  ) else $error("cdc_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== logic/cmd_issuer.sv ====
// Source-domain command issuer that stamps sequence numbers and feeds the crossing FIFO
`default_nettype none

`include "cdc_macros.svh"

module cmd_issuer
  import cdc_pkg::*;
(
  input  wire logic                      src_clk_i,
  input  wire logic                      src_rst_ni,
  input  wire logic                      cmd_valid_i,
  input  wire opcode_e                   cmd_op_i,
  input  wire logic [`CMD_OPERAND_W-1:0] cmd_operand_i,
  output logic                           cmd_ready_o,
  output cmd_word_t                      push_word_o,
  output logic                           push_valid_o,
  input  wire logic                      push_ready_i
);

  cmd_word_t             word_q;
  logic                  valid_q;
  logic [`CMD_SEQ_W-1:0] seq_q;
  logic                  accept;

  // The single slot can take a new command if empty or if it drains this cycle
  assign cmd_ready_o = !valid_q || push_ready_i;
  assign accept      = cmd_valid_i && cmd_ready_o;

  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      valid_q <= 1'b0;
      seq_q   <= '0;
    end else if (accept) begin
      valid_q <= 1'b1;
      // Wraps back to zero after the last value
      seq_q   <= seq_q + 1'b1;
    end else if (push_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload of the slot, only meaningful while valid_q is set
  always_ff @(posedge src_clk_i) begin
    if (accept) begin
      word_q.op      <= cmd_op_i;
      word_q.seq     <= seq_q;
      word_q.operand <= cmd_operand_i;
    end
  end

  assign push_word_o  = word_q;
  assign push_valid_o = valid_q;

  // A stalled push keeps both its valid and its word until the FIFO takes it
  push_hold_a : assert property (
    @(posedge src_clk_i) disable iff (!src_rst_ni)
    (push_valid_o && !push_ready_i) |=> (push_valid_o && $stable(push_word_o))
  ) else $error("cmd_issuer: push word changed while stalled");

endmodule

`default_nettype wire

// ==== logic/cmd_accumulator.sv ====
// Destination-domain consumer that executes popped commands on a 16-bit accumulator
`default_nettype none

`include "cdc_macros.svh"

module cmd_accumulator
  import cdc_pkg::*;
(
  input  wire logic                 dst_clk_i,
  input  wire logic                 dst_rst_ni,
  input  wire cmd_word_t            pop_word_i,
  input  wire logic                 pop_valid_i,
  output logic                      pop_ready_o,
  output logic [`CMD_OPERAND_W-1:0] result_o,
  output logic                      result_valid_o,
  input  wire logic                 result_ready_i,
  output logic                      seq_error_o
);

  acc_state_e                state_q;
  acc_state_e                state_d;
  logic [`CMD_OPERAND_W-1:0] acc_q;
  logic [`CMD_OPERAND_W-1:0] acc_d;
  logic [`CMD_SEQ_W-1:0]     exp_seq_q;
  logic                      seq_err_q;
  logic                      pop;

  // Only one command is in flight, the next pop waits for the result handshake
  assign pop_ready_o = (state_q == ACC_IDLE);
  assign pop         = pop_valid_i && pop_ready_o;

  // Result of the popped opcode, wrapping at the accumulator width
  always_comb begin
    case (pop_word_i.op)
      OP_LOAD: acc_d = pop_word_i.operand;
      OP_ADD:  acc_d = acc_q + pop_word_i.operand;
      OP_SUB:  acc_d = acc_q - pop_word_i.operand;
      OP_XOR:  acc_d = acc_q ^ pop_word_i.operand;
      default: acc_d = acc_q;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ACC_IDLE: begin
        if (pop) begin
          state_d = ACC_HOLD;
        end
      end
      ACC_HOLD: begin
        if (result_ready_i) begin
          state_d = ACC_IDLE;
        end
      end
      default: state_d = ACC_IDLE;
    endcase
  end

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      state_q   <= ACC_IDLE;
      acc_q     <= '0;
      exp_seq_q <= '0;
      seq_err_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (pop) begin
        acc_q     <= acc_d;
        exp_seq_q <= exp_seq_q + 1'b1;
        // Sticky, a single gap or repeat is enough to flag the stream
        if (pop_word_i.seq != exp_seq_q) begin
          seq_err_q <= 1'b1;
        end
      end
    end
  end

  // The accumulator itself is the result, it only changes on a pop
  assign result_o       = acc_q;
  assign result_valid_o = (state_q == ACC_HOLD);
  assign seq_error_o    = seq_err_q;

  // An offered result must survive until the consumer takes it
  result_hold_a : assert property (
    @(posedge dst_clk_i) disable iff (!dst_rst_ni)
    (result_valid_o && !result_ready_i) |=> (result_valid_o && $stable(result_o))
  ) else $error("cmd_accumulator: result changed while stalled");

endmodule

`default_nettype wire

// ==== logic/cdc_cmd_top.sv ====
// Top level of the command crossing, issuer to FIFO to accumulator, instantiated by the testbench
`default_nettype none

`include "cdc_macros.svh"

module cdc_cmd_top
  import cdc_pkg::*;
(
  input  wire logic                      src_clk_i,
  input  wire logic                      src_rst_ni,
  input  wire logic                      dst_clk_i,
  input  wire logic                      dst_rst_ni,

  // Command port, source domain
  input  wire logic                      cmd_valid_i,
  input  wire opcode_e                   cmd_op_i,
  input  wire logic [`CMD_OPERAND_W-1:0] cmd_operand_i,
  output logic                           cmd_ready_o,

  // Result port, destination domain
  output logic      [`CMD_OPERAND_W-1:0] result_o,
  output logic                           result_valid_o,
  input  wire logic                      result_ready_i,
  output logic                           seq_error_o
);

  // Source side of the FIFO
  cmd_word_t push_word;
  logic      push_valid;
  logic      push_ready;

  // Destination side of the FIFO
  cmd_word_t pop_word;
  logic      pop_valid;
  logic      pop_ready;

  cmd_issuer i_issuer (
    .src_clk_i     (src_clk_i),
    .src_rst_ni    (src_rst_ni),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_op_i      (cmd_op_i),
    .cmd_operand_i (cmd_operand_i),
    .cmd_ready_o   (cmd_ready_o),
    .push_word_o   (push_word),
    .push_valid_o  (push_valid),
    .push_ready_i  (push_ready)
  );

  cdc_fifo #(
    .T         (cmd_word_t),
    .LOG_DEPTH (`CDC_LOG_DEPTH)
  ) i_fifo (
    .src_rst_ni  (src_rst_ni),
    .src_clk_i   (src_clk_i),
    .src_data_i  (push_word),
    .src_valid_i (push_valid),
    .src_ready_o (push_ready),
    .dst_rst_ni  (dst_rst_ni),
    .dst_clk_i   (dst_clk_i),
    .dst_data_o  (pop_word),
    .dst_valid_o (pop_valid),
    .dst_ready_i (pop_ready)
  );

  cmd_accumulator i_accumulator (
    .dst_clk_i      (dst_clk_i),
    .dst_rst_ni     (dst_rst_ni),
    .pop_word_i     (pop_word),
    .pop_valid_i    (pop_valid),
    .pop_ready_o    (pop_ready),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .seq_error_o    (seq_error_o)
  );

endmodule

`default_nettype wire

// ==== verification/cdc_cmd_tb.sv ====
// Self-checking testbench that sends random commands through cdc_cmd_top and checks every result
`default_nettype none

`include "cdc_macros.svh"

module cdc_cmd_tb
  import cdc_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SRC_HALF    = 10;
  localparam int DST_HALF    = 17;
  localparam int DST_PERIOD  = 2 * DST_HALF;
  localparam int NUM_RANDOM  = 300;
  localparam int NUM_BP      = 24;
  localparam int BP_LIMIT    = 12;
  localparam int DRAIN_LIMIT = 400;
  localparam int TIMEOUT_NS  = (NUM_RANDOM + NUM_BP) * 40 * DST_PERIOD + 2000;
  localparam int W           = `CMD_OPERAND_W;

  logic         src_clk = 1'b0;
  logic         dst_clk = 1'b0;
  logic         src_rst_n;
  logic         dst_rst_n;
  logic         cmd_valid;
  opcode_e      cmd_op;
  logic [W-1:0] cmd_operand;
  logic         cmd_ready;
  logic [W-1:0] result;
  logic         result_valid;
  logic         result_ready;
  logic         seq_error;

  // Model state: commands accepted but not yet answered, oldest first
  logic [W+1:0] model_q[$];
  logic [W-1:0] model_acc = '0;
  integer       seed = 5684;
  int           accepted_cnt = 0;
  int           results_cnt = 0;
  int           err_cnt = 0;
  int           pass_cnt = 0;
  int           fail_cnt = 0;
  int           stall_accepts = 0;
  logic         stall_seen = 1'b0;
  logic         seq_seen = 1'b0;
  logic         hold_ready = 1'b0;

  always #SRC_HALF src_clk = ~src_clk;
  always #DST_HALF dst_clk = ~dst_clk;

  cdc_cmd_top dut_i (
    .src_clk_i      (src_clk),
    .src_rst_ni     (src_rst_n),
    .dst_clk_i      (dst_clk),
    .dst_rst_ni     (dst_rst_n),
    .cmd_valid_i    (cmd_valid),
    .cmd_op_i       (cmd_op),
    .cmd_operand_i  (cmd_operand),
    .cmd_ready_o    (cmd_ready),
    .result_o       (result),
    .result_valid_o (result_valid),
    .result_ready_i (result_ready),
    .seq_error_o    (seq_error)
  );

  // Accumulator rule per opcode, wrapping at the operand width
  function automatic logic [W-1:0] apply_cmd(input logic [W-1:0] acc, input opcode_e op,
                                             input logic [W-1:0] operand);
    case (op)
      OP_LOAD: return operand;
      OP_ADD:  return acc + operand;
      OP_SUB:  return acc - operand;
      default: return acc ^ operand;
    endcase
  endfunction

  // Called 2 ns after a source edge, returns 2 ns after the edge that took the command
  task automatic send_cmd(input opcode_e op, input logic [W-1:0] operand);
    cmd_op      = op;
    cmd_operand = operand;
    cmd_valid   = 1'b1;
    do @(posedge src_clk); while (!cmd_ready);
    #2;
    cmd_valid = 1'b0;
  endtask

  task automatic check_idle_outputs();
    assert (cmd_ready === 1'b1) else begin
      $display("MISMATCH cmd_ready_o expected 0x1 got 0x%h", cmd_ready);
      err_cnt++;
    end
    assert (result_valid === 1'b0) else begin
      $display("MISMATCH result_valid_o expected 0x0 got 0x%h", result_valid);
      err_cnt++;
    end
    assert (seq_error === 1'b0) else begin
      $display("MISMATCH seq_error_o expected 0x0 got 0x%h", seq_error);
      err_cnt++;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((results_cnt != accepted_cnt) && (cycles < DRAIN_LIMIT)) begin
      @(posedge dst_clk);
      #1;
      cycles++;
    end
    assert (results_cnt == accepted_cnt) else begin
      $display("Results stopped arriving, %0d of %0d commands answered",
               results_cnt, accepted_cnt);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    int errs;
    errs = err_cnt - err_before;
    if (errs == 0) begin
      pass_cnt++;
      $display("PASS %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL %s with %0d errors", name, errs);
    end
  endtask

  // Source monitor: record each accepted command and the first stalled one
  always @(posedge src_clk) begin
    if (src_rst_n && cmd_valid) begin
      if (cmd_ready) begin
        model_q.push_back({cmd_op, cmd_operand});
        accepted_cnt++;
      end else if (!stall_seen) begin
        stall_seen    = 1'b1;
        stall_accepts = accepted_cnt;
      end
    end
  end

  // Result monitor: every handshake answers the oldest command still pending
  always @(posedge dst_clk) begin
    logic [W+1:0] entry;
    if (dst_rst_n) begin
      if (seq_error) begin
        seq_seen = 1'b1;
      end
      if (result_valid && result_ready) begin
        results_cnt++;
        assert (model_q.size() > 0) else begin
          $display("Result 0x%h arrived with no command pending", result);
          err_cnt++;
        end
        if (model_q.size() > 0) begin
          entry     = model_q.pop_front();
          model_acc = apply_cmd(model_acc, opcode_e'(entry[W+1:W]), entry[W-1:0]);
          assert (result === model_acc) else begin
            $display("MISMATCH result_o expected 0x%h got 0x%h", model_acc, result);
            err_cnt++;
          end
        end
      end
    end
  end

  // Result consumer, low 30 % of the time unless held off
  always @(posedge dst_clk) begin
    #2;
    if (hold_ready) begin
      result_ready = 1'b0;
    end else begin
      result_ready = ($unsigned($random(seed)) % 100) >= 30;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int err_before;
    int gap;
    int i;
    src_rst_n    = 1'b0;
    dst_rst_n    = 1'b0;
    cmd_valid    = 1'b0;
    cmd_op       = OP_LOAD;
    cmd_operand  = '0;
    result_ready = 1'b0;

    // Outputs idle during reset and just after release
    err_before = err_cnt;
    repeat (10) begin
      @(posedge src_clk);
      check_idle_outputs();
    end
    #2;
    src_rst_n = 1'b1;
    dst_rst_n = 1'b1;
    repeat (3) begin
      @(posedge src_clk);
      check_idle_outputs();
    end
    report_test("reset", err_before);

    // Random opcodes, operands and gaps, compared result by result
    err_before = err_cnt;
    @(posedge src_clk);
    #2;
    for (i = 0; i < NUM_RANDOM; i++) begin
      send_cmd(opcode_e'(2'($random(seed))), W'($random(seed)));
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) begin
        @(posedge src_clk);
        #2;
      end
    end
    wait_drain();
    report_test("random order and value", err_before);

    // Results held off while commands keep coming until the input stalls
    err_before = err_cnt;
    @(posedge src_clk);
    #2;
    stall_seen = 1'b0;
    hold_ready = 1'b1;
    fork
      begin
        for (i = 0; i < NUM_BP; i++) begin
          send_cmd(opcode_e'(2'($random(seed))), W'($random(seed)));
        end
      end
      begin
        gap = accepted_cnt;
        while (!stall_seen && (accepted_cnt - gap) <= BP_LIMIT) begin
          @(posedge src_clk);
          #1;
        end
        assert (stall_seen && (stall_accepts - gap) <= BP_LIMIT) else begin
          $display("cmd_ready_o did not fall within %0d accepted commands", BP_LIMIT);
          err_cnt++;
        end
        hold_ready = 1'b0;
      end
    join
    wait_drain();
    report_test("back-pressure", err_before);

    // The sequence counter wrapped and the accumulator never saw a gap
    err_before = err_cnt;
    assert (!seq_seen) else begin
      $display("MISMATCH seq_error_o expected 0x0 got 0x1");
      err_cnt++;
    end
    assert (accepted_cnt > 16) else begin
      $display("Only %0d commands were sent, too few to wrap the sequence", accepted_cnt);
      err_cnt++;
    end
    report_test("sequence integrity", err_before);

    // Every command answered once and nothing more is offered
    err_before = err_cnt;
    assert ((results_cnt == accepted_cnt) && (model_q.size() == 0)) else begin
      $display("Drain left %0d results for %0d commands", results_cnt, accepted_cnt);
      err_cnt++;
    end
    repeat (20) begin
      @(posedge dst_clk);
      #1;
      assert (result_valid === 1'b0) else begin
        $display("MISMATCH result_valid_o expected 0x0 got 0x%h", result_valid);
        err_cnt++;
      end
    end
    report_test("drain", err_before);

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (err_cnt == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+logic
logic/cdc_pkg.sv
logic/cdc_2phase.sv
logic/cdc_fifo.sv
logic/cmd_issuer.sv
logic/cmd_accumulator.sv
logic/cdc_cmd_top.sv
verification/cdc_cmd_tb.sv
